// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_bt_tx_bitp
RTL_TOP   ?= bt_tx_bitp
FLIST     ?= bt_tx_bitp.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell grep -v '^+' $(FLIST))
RTL_SRCS := $(filter rtl/%,$(SRCS))
HDRS     := $(wildcard include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation PASSED$$" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bt_tx_bitp.f
+incdir+include
rtl/bt_pkt_pkg.sv
rtl/bt_buf_pkg.sv
rtl/buf_bus_if.sv
rtl/txbuf_arbiter.sv
rtl/header_encoder.sv
rtl/payload_reader.sv
rtl/tx_sequencer.sv
rtl/bt_tx_bitp.sv
sim/tb_bt_tx_bitp.sv

// File: rtl/bt_buf_pkg.sv
package bt_buf_pkg;

  localparam int WORD_W = 32;
  localparam int ADDR_W = 8;

  typedef logic [WORD_W-1:0] buf_word_t;
  typedef logic [ADDR_W-1:0] buf_addr_t;

  // owner of the buffer port
  typedef enum logic {
    CL_HOST    = 1'b0,
    CL_PAYLOAD = 1'b1
  } client_e;

endpackage

// File: rtl/bt_pkt_pkg.sv
package bt_pkt_pkg;

  typedef enum logic [3:0] {
    NULL_PK = 4'h0,
    POLL_PK = 4'h1,
    DM1_PK  = 4'h3,
    DH1_PK  = 4'h4
  } pk_type_e;

  localparam int HDR_BITS = 10;  // lt_addr, type, flow, arqn, seqn
  localparam int HEC_BITS = 8;

  // top term of each generator is implied
  localparam logic [7:0]  HEC_POLY    = 8'hA7;     // x^8+x^7+x^5+x^2+x+1
  localparam logic [15:0] CRC_POLY    = 16'h1021;  // x^16+x^12+x^5+1
  localparam logic [6:0]  WHITEN_POLY = 7'h11;     // x^7+x^4+1

  typedef logic [2:0] lt_addr_t;
  typedef logic [7:0] uap_t;
  typedef logic [9:0] pylen_t;  // bytes

endpackage

// File: rtl/bt_tx_bitp.sv
`timescale 1ns/1ps

module bt_tx_bitp #(
  parameter int BUF_DEPTH = 256
) (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  p_1us,
  input  logic                  tx_start,
  input  bt_pkt_pkg::lt_addr_t  lt_addr,
  input  bt_pkt_pkg::pk_type_e  pk_type,
  input  logic                  flow,
  input  logic                  arqn,
  input  logic                  seqn,
  input  bt_pkt_pkg::uap_t      uap,
  input  bt_pkt_pkg::pylen_t    pylen,
  input  logic                  whiten_en,
  input  logic [5:0]            whiten_init,
  input  logic                  host_req,
  input  logic                  host_we,
  input  bt_buf_pkg::buf_addr_t host_addr,
  input  bt_buf_pkg::buf_word_t host_wdata,
  output logic                  host_ack,
  output bt_buf_pkg::buf_word_t host_rdata,
  output logic                  txbit,
  output logic                  txbit_strobe,
  output logic                  tx_busy,
  output logic                  tx_done
);

  logic hdr_load, hdr_shift, hdr_bit, hdr_last;
  logic py_start, py_shift, py_bit, py_last;

  buf_bus_if host_bus ();
  buf_bus_if py_bus ();

  assign host_bus.req   = host_req;
  assign host_bus.we    = host_we;
  assign host_bus.addr  = host_addr;
  assign host_bus.wdata = host_wdata;
  assign host_ack       = host_bus.ack;
  assign host_rdata     = host_bus.rdata;

  txbuf_arbiter #(.BUF_DEPTH(BUF_DEPTH)) txbuf_arbiter_u (
    .clk_6M (clk_6M  ),
    .rstz   (rstz    ),
    .host   (host_bus),
    .py     (py_bus  )
  );

  header_encoder header_encoder_u (
    .*,
    .load   (hdr_load ),
    .shift  (hdr_shift)
  );

  payload_reader payload_reader_u (
    .*,
    .start  (py_start ),
    .shift  (py_shift ),
    .bus    (py_bus   )
  );

  // all sequencer ports match top-level names
  tx_sequencer tx_sequencer_u (.*);

endmodule

// File: rtl/buf_bus_if.sv
`timescale 1ns/1ps

interface buf_bus_if;

  logic                  req;
  logic                  ack;
  logic                  we;
  bt_buf_pkg::buf_addr_t addr;
  bt_buf_pkg::buf_word_t wdata;
  bt_buf_pkg::buf_word_t rdata;  // valid while ack high

  modport client (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport buffer (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// File: rtl/header_encoder.sv
`timescale 1ns/1ps

module header_encoder (
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 load,
  input  logic                 shift,
  input  bt_pkt_pkg::lt_addr_t lt_addr,
  input  bt_pkt_pkg::pk_type_e pk_type,
  input  logic                 flow,
  input  logic                 arqn,
  input  logic                 seqn,
  input  bt_pkt_pkg::uap_t     uap,
  output logic                 hdr_bit,
  output logic                 hdr_last
);

  localparam int TOTAL = bt_pkt_pkg::HDR_BITS + bt_pkt_pkg::HEC_BITS;

  logic [bt_pkt_pkg::HDR_BITS-1:0] hdr_sr;
  logic [bt_pkt_pkg::HEC_BITS-1:0] hec;
  logic [4:0]                      cnt;
  logic                            in_hdr;

  function automatic logic [7:0] hec_step(input logic [7:0] r, input logic d);
    logic fb;
    fb = d ^ r[7];
    return {r[6:0], 1'b0} ^ (fb ? bt_pkt_pkg::HEC_POLY : 8'h00);
  endfunction

  assign in_hdr   = (cnt < 5'(bt_pkt_pkg::HDR_BITS));
  assign hdr_bit  = in_hdr ? hdr_sr[0] : hec[bt_pkt_pkg::HEC_BITS-1];  // hec msb first
  assign hdr_last = (cnt == 5'(TOTAL - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      cnt <= 5'(TOTAL);  // parked, nothing to send
    else if (load)
      cnt <= 5'd0;
    else if (shift && cnt != 5'(TOTAL))
      cnt <= cnt + 5'd1;
  end

  // hec lfsr runs over the header bits as they leave, then shifts itself out
  always_ff @(posedge clk_6M)
  begin
    if (load)
    begin
      hdr_sr <= {seqn, arqn, flow, pk_type, lt_addr};
      hec    <= uap;
    end
    else if (shift)
    begin
      hdr_sr <= hdr_sr >> 1;
      if (in_hdr)
        hec <= hec_step(hec, hdr_sr[0]);
      else
        hec <= hec << 1;
    end
  end

endmodule

// File: rtl/payload_reader.sv
`timescale 1ns/1ps

module payload_reader (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               start,
  input  logic               shift,
  input  bt_pkt_pkg::pylen_t pylen,
  input  bt_pkt_pkg::uap_t   uap,
  buf_bus_if.client          bus,
  output logic               py_bit,
  output logic               py_last
);

  logic [13:0]           bcnt;   // position in data + crc
  logic [13:0]           nbits;  // data bits of this packet
  logic [15:0]           crc;
  bt_buf_pkg::buf_word_t cur_word;
  bt_buf_pkg::buf_word_t nxt_word;
  logic                  nxt_valid;
  logic                  in_data;
  logic                  word_first;
  logic                  fetch_more;
  logic                  data_bit;

  function automatic logic [15:0] crc_step(input logic [15:0] r, input logic d);
    logic fb;
    fb = d ^ r[15];
    return {r[14:0], 1'b0} ^ (fb ? bt_pkt_pkg::CRC_POLY : 16'h0000);
  endfunction

  assign in_data    = (bcnt < nbits);
  assign word_first = (bcnt[4:0] == 5'd0);
  assign fetch_more = (bcnt + 14'd32 < nbits);
  assign data_bit   = word_first ? nxt_word[0] : cur_word[0];
  assign py_bit     = in_data ? data_bit : crc[15];
  assign py_last    = (bcnt == nbits + 14'd15);

  assign bus.we    = 1'b0;  // read only client
  assign bus.wdata = '0;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bcnt      <= '0;
      nbits     <= '0;
      bus.req   <= 1'b0;
      bus.addr  <= '0;
      nxt_valid <= 1'b0;
    end
    else if (start)
    begin
      bcnt      <= '0;
      nbits     <= {1'b0, pylen, 3'b000};
      bus.req   <= 1'b1;  // word 0 prefetch
      bus.addr  <= '0;
      nxt_valid <= 1'b0;
    end
    else
    begin
      if (bus.req && bus.ack)
      begin
        bus.req   <= 1'b0;
        nxt_valid <= 1'b1;
      end
      else if (shift && in_data && word_first)
      begin
        nxt_valid <= 1'b0;  // consumed into cur_word
        if (fetch_more)
        begin
          bus.req  <= 1'b1;
          bus.addr <= bus.addr + 1'b1;
        end
      end
      if (shift)
        bcnt <= bcnt + 14'd1;
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (bus.req && bus.ack)
      nxt_word <= bus.rdata;
    if (shift && in_data)
      cur_word <= word_first ? (nxt_word >> 1) : (cur_word >> 1);
    if (start)
      crc <= {8'h00, uap};
    else if (shift)
    begin
      if (in_data)
        crc <= crc_step(crc, data_bit);
      else
        crc <= crc << 1;
    end
  end

  // arbiter latency must stay inside one word time
  assert property (@(posedge clk_6M) disable iff (!rstz)
    (shift && in_data && word_first) |-> nxt_valid)
    else $error("payload underrun at bit %0d", bcnt);

endmodule

// File: rtl/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer (
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 p_1us,
  input  logic                 tx_start,
  input  bt_pkt_pkg::pk_type_e pk_type,
  input  logic                 whiten_en,
  input  logic [5:0]           whiten_init,
  input  logic                 hdr_bit,
  input  logic                 hdr_last,
  input  logic                 py_bit,
  input  logic                 py_last,
  output logic                 hdr_load,
  output logic                 hdr_shift,
  output logic                 py_start,
  output logic                 py_shift,
  output logic                 txbit,
  output logic                 txbit_strobe,
  output logic                 tx_busy,
  output logic                 tx_done
);

  typedef enum logic [1:0] {ST_IDLE, ST_HEADER, ST_PAYLOAD, ST_DONE} state_e;

  state_e     state;
  logic       has_py;
  logic       wh_on;
  logic [6:0] wreg;  // whitening lfsr
  logic       bit_tick;
  logic       raw_bit;

  assign bit_tick  = p_1us && (state == ST_HEADER || state == ST_PAYLOAD);
  assign hdr_load  = tx_start && (state == ST_IDLE);
  assign py_start  = hdr_load;  // reader prefetches during the header
  assign hdr_shift = p_1us && (state == ST_HEADER);
  assign py_shift  = p_1us && (state == ST_PAYLOAD);
  assign raw_bit   = (state == ST_HEADER) ? hdr_bit : py_bit;
  assign tx_busy   = (state != ST_IDLE);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state        <= ST_IDLE;
      has_py       <= 1'b0;
      wh_on        <= 1'b0;
      txbit_strobe <= 1'b0;
      tx_done      <= 1'b0;
    end
    else
    begin
      txbit_strobe <= bit_tick;
      tx_done      <= (state == ST_DONE);
      case (state)
        ST_IDLE:
          if (tx_start)
          begin
            state  <= ST_HEADER;
            has_py <= (pk_type != bt_pkt_pkg::NULL_PK) && (pk_type != bt_pkt_pkg::POLL_PK);
            wh_on  <= whiten_en;
          end
        ST_HEADER:
          if (p_1us && hdr_last)
            state <= has_py ? ST_PAYLOAD : ST_DONE;
        ST_PAYLOAD:
          if (p_1us && py_last)
            state <= ST_DONE;
        default:
          state <= ST_IDLE;  // last strobe is out this cycle
      endcase
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (hdr_load)
      wreg <= {1'b1, whiten_init};
    else if (bit_tick)
      wreg <= {wreg[5:0], 1'b0} ^ (wreg[6] ? bt_pkt_pkg::WHITEN_POLY : 7'h00);
    if (bit_tick)
      txbit <= raw_bit ^ (wh_on & wreg[6]);
  end

endmodule

// File: rtl/txbuf_arbiter.sv
`timescale 1ns/1ps

module txbuf_arbiter #(
  parameter int BUF_DEPTH = 256
) (
  input logic       clk_6M,
  input logic       rstz,
  buf_bus_if.buffer host,
  buf_bus_if.buffer py
);

  typedef enum logic [1:0] {AR_IDLE, AR_ACCESS, AR_ACK} ar_state_e;

  ar_state_e             st;
  bt_buf_pkg::client_e   grant;  // current or last owner
  bt_buf_pkg::buf_word_t mem [BUF_DEPTH];
  bt_buf_pkg::buf_word_t rdata_q;
  logic                  sel_req;
  logic                  sel_we;
  bt_buf_pkg::buf_addr_t sel_addr;
  bt_buf_pkg::buf_word_t sel_wdata;

  assign sel_req   = (grant == bt_buf_pkg::CL_HOST) ? host.req   : py.req;
  assign sel_we    = (grant == bt_buf_pkg::CL_HOST) ? host.we    : py.we;
  assign sel_addr  = (grant == bt_buf_pkg::CL_HOST) ? host.addr  : py.addr;
  assign sel_wdata = (grant == bt_buf_pkg::CL_HOST) ? host.wdata : py.wdata;

  assign host.ack   = (st == AR_ACK) && (grant == bt_buf_pkg::CL_HOST);
  assign py.ack     = (st == AR_ACK) && (grant == bt_buf_pkg::CL_PAYLOAD);
  assign host.rdata = rdata_q;
  assign py.rdata   = rdata_q;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      st    <= AR_IDLE;
      grant <= bt_buf_pkg::CL_PAYLOAD;  // host wins the first tie
    end
    else
    begin
      case (st)
        AR_IDLE:
          if (host.req && py.req)
          begin
            grant <= (grant == bt_buf_pkg::CL_HOST) ? bt_buf_pkg::CL_PAYLOAD
                                                    : bt_buf_pkg::CL_HOST;
            st    <= AR_ACCESS;
          end
          else if (host.req || py.req)
          begin
            grant <= host.req ? bt_buf_pkg::CL_HOST : bt_buf_pkg::CL_PAYLOAD;
            st    <= AR_ACCESS;
          end
        AR_ACCESS:
          st <= AR_ACK;
        default:
          if (!sel_req)  // phase 3 seen, drop ack
            st <= AR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (st == AR_ACCESS)
    begin
      if (sel_we)
        mem[sel_addr] <= sel_wdata;
      else
        rdata_q <= mem[sel_addr];
    end
  end

  // ack answers a req that has been up since arbitration
  assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(host.ack) |-> host.req && $past(host.req, 2));
  assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(py.ack) |-> py.req && $past(py.req, 2));

endmodule

// File: include/bt_tx_models.svh
`ifndef BT_TX_MODELS_SVH
`define BT_TX_MODELS_SVH

// header bits enter lsb first, result goes out msb first
function automatic logic [7:0] hec_of_header(input logic [9:0] hdr, input logic [7:0] uap);
  logic [7:0] r;
  logic       fb;
  r = uap;
  for (int i = 0; i < bt_pkt_pkg::HDR_BITS; i++)
  begin
    fb = hdr[i] ^ r[7];
    // taps of x^8+x^7+x^5+x^2+x+1
    r  = {r[6] ^ fb, r[5], r[4] ^ fb, r[3:2], r[1] ^ fb, r[0] ^ fb, fb};
  end
  return r;
endfunction

// one payload byte lsb first into a register seeded with {8'h00, uap}
function automatic logic [15:0] crc16_add_byte(input logic [15:0] crc, input logic [7:0] b);
  logic [15:0] r;
  logic        fb;
  r = crc;
  for (int i = 0; i < 8; i++)
  begin
    fb = b[i] ^ r[15];
    r  = {r[14:12], r[11] ^ fb, r[10:5], r[4] ^ fb, r[3:0], fb};  // x^16+x^12+x^5+1
  end
  return r;
endfunction

// bit 6 of the whitening state is xored into the current bit
function automatic logic [6:0] whiten_seed(input logic [5:0] init);
  return {1'b1, init};
endfunction

function automatic logic [6:0] whiten_advance(input logic [6:0] w);
  return {w[5:4], w[3] ^ w[6], w[2:0], w[6]};  // x^7+x^4+1
endfunction

`endif

// File: sim/tb_bt_tx_bitp.sv
`timescale 1ns/1ps

module tb_bt_tx_bitp;

  `include "bt_tx_models.svh"

  localparam int NROWS     = 5;
  localparam int ACK_LIMIT = 64;
  localparam int PKT_LIMIT = 20000;  // cycles
  localparam int HI_ADDR   = 128;    // host traffic while a packet is out

  typedef struct {
    bt_pkt_pkg::lt_addr_t lt_addr;
    bt_pkt_pkg::pk_type_e pk_type;
    logic                 flow;
    logic                 arqn;
    logic                 seqn;
    bt_pkt_pkg::uap_t     uap;
    bt_pkt_pkg::pylen_t   pylen;
    logic                 whiten_en;
    logic [5:0]           whiten_init;
  } row_t;

  logic                  clk_6M = 1'b0;
  logic                  rstz;
  logic                  p_1us = 1'b0;
  logic [2:0]            pcnt = 3'd0;
  logic                  tx_start;
  bt_pkt_pkg::lt_addr_t  lt_addr;
  bt_pkt_pkg::pk_type_e  pk_type;
  logic                  flow;
  logic                  arqn;
  logic                  seqn;
  bt_pkt_pkg::uap_t      uap;
  bt_pkt_pkg::pylen_t    pylen;
  logic                  whiten_en;
  logic [5:0]            whiten_init;
  logic                  host_req;
  logic                  host_we;
  bt_buf_pkg::buf_addr_t host_addr;
  bt_buf_pkg::buf_word_t host_wdata;
  logic                  host_ack;
  bt_buf_pkg::buf_word_t host_rdata;
  logic                  txbit;
  logic                  txbit_strobe;
  logic                  tx_busy;
  logic                  tx_done;

  row_t                  rows [NROWS];
  logic [7:0]            pbytes [1024];
  bt_buf_pkg::buf_word_t shadow [256];
  logic                  written [256];
  logic                  exp_bits [$];
  logic                  got_bits [$];
  int                    n_mismatch;
  int                    n_proto;
  logic                  busy_q;
  logic                  ack_q;
  logic                  req_q;

  bt_tx_bitp #(.BUF_DEPTH(256)) DUT (.*);

  always #2 clk_6M = ~clk_6M;

  // 1 us tick out of the 6 MHz clock
  always @(posedge clk_6M)
  begin
    if (!rstz)
    begin
      pcnt  <= 3'd0;
      p_1us <= 1'b0;
    end
    else
    begin
      pcnt  <= (pcnt == 3'd5) ? 3'd0 : pcnt + 3'd1;
      p_1us <= (pcnt == 3'd5);
    end
  end

  always @(negedge clk_6M)
  begin
    if (!rstz)
    begin
      busy_q = 1'b0;
      ack_q  = 1'b0;
      req_q  = 1'b0;
    end
    else
    begin
      if (!tx_busy && txbit_strobe)
      begin
        $display("Error: txbit_strobe pulsed while tx_busy was low");
        n_proto++;
      end
      if (tx_done && !busy_q)  // done only right after busy falls
      begin
        $display("Error: tx_done pulsed outside the end of a packet");
        n_proto++;
      end
      if ((host_ack && !ack_q && !host_req) || (host_ack && !host_req && !req_q))
      begin
        $display("Error: host_ack high without a pending host_req");
        n_proto++;
      end
      busy_q = tx_busy;
      ack_q  = host_ack;
      req_q  = host_req;
    end
  end

  function automatic logic carries_payload(input bt_pkt_pkg::pk_type_e t);
    return (t != bt_pkt_pkg::NULL_PK) && (t != bt_pkt_pkg::POLL_PK);
  endfunction

  task automatic fail_timeout(input string what);
    $display("Error: timed out waiting for %s", what);
    n_proto++;
    $display("errors: %0d mismatches, %0d protocol", n_mismatch, n_proto);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic host_access(input logic we, input bt_buf_pkg::buf_addr_t a,
                             input bt_buf_pkg::buf_word_t d,
                             output bt_buf_pkg::buf_word_t rd);
    int n;
    if (host_ack)
    begin
      $display("Error: host_ack still high before a new request");
      n_proto++;
    end
    @(posedge clk_6M);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= a;
    host_wdata <= d;
    n = 0;
    do
    begin
      @(negedge clk_6M);
      n++;
    end
    while (!host_ack && n < ACK_LIMIT);
    if (!host_ack)
      fail_timeout("host_ack to rise");
    else
    begin
      rd = host_rdata;  // valid while ack high
      @(posedge clk_6M);
      host_req <= 1'b0;
      n = 0;
      do
      begin
        @(negedge clk_6M);
        n++;
      end
      while (host_ack && n < ACK_LIMIT);
      if (host_ack)
        fail_timeout("host_ack to fall");
    end
  endtask

  task automatic write_word(input bt_buf_pkg::buf_addr_t a, input bt_buf_pkg::buf_word_t d);
    bt_buf_pkg::buf_word_t dummy;
    host_access(1'b1, a, d, dummy);
    shadow[a]  = d;
    written[a] = 1'b1;
  endtask

  // header lsb first, hec msb first, payload bytes lsb first, crc msb first
  task automatic build_expected(input row_t r);
    logic [9:0]  hdr;
    logic [7:0]  hec;
    logic [15:0] crc;
    logic [6:0]  w;
    exp_bits.delete();
    hdr = {r.seqn, r.arqn, r.flow, r.pk_type, r.lt_addr};
    hec = hec_of_header(hdr, r.uap);
    for (int i = 0; i < 10; i++)
      exp_bits.push_back(hdr[i]);
    for (int i = 7; i >= 0; i--)
      exp_bits.push_back(hec[i]);
    if (carries_payload(r.pk_type))
    begin
      crc = {8'h00, r.uap};
      for (int i = 0; i < int'(r.pylen); i++)
      begin
        for (int j = 0; j < 8; j++)
          exp_bits.push_back(pbytes[i][j]);
        crc = crc16_add_byte(crc, pbytes[i]);
      end
      for (int i = 15; i >= 0; i--)
        exp_bits.push_back(crc[i]);
    end
    if (r.whiten_en)
    begin
      w = whiten_seed(r.whiten_init);
      foreach (exp_bits[i])
      begin
        exp_bits[i] = exp_bits[i] ^ w[6];
        w = whiten_advance(w);
      end
    end
  endtask

  task automatic start_packet(input row_t r);
    @(posedge clk_6M);
    lt_addr     <= r.lt_addr;
    pk_type     <= r.pk_type;
    flow        <= r.flow;
    arqn        <= r.arqn;
    seqn        <= r.seqn;
    uap         <= r.uap;
    pylen       <= r.pylen;
    whiten_en   <= r.whiten_en;
    whiten_init <= r.whiten_init;
    tx_start    <= 1'b1;
    @(posedge clk_6M);
    tx_start <= 1'b0;
    @(negedge clk_6M);
    if (!tx_busy)
    begin
      $display("Error: tx_busy did not rise after tx_start");
      n_proto++;
    end
  endtask

  task automatic collect_packet();
    int n;
    got_bits.delete();
    n = 0;
    do
    begin
      @(negedge clk_6M);
      n++;
      if (txbit_strobe)
        got_bits.push_back(txbit);
    end
    while (!tx_done && n < PKT_LIMIT);
    if (!tx_done)
      fail_timeout("tx_done");
  endtask

  // a start pulse in the middle of a packet must be ignored
  task automatic start_while_busy();
    int n;
    int seen;
    n    = 0;
    seen = 0;
    while (seen < 10 && n < PKT_LIMIT)
    begin
      @(negedge clk_6M);
      n++;
      if (txbit_strobe)
        seen++;
    end
    if (seen < 10)
      fail_timeout("strobes before the extra tx_start");
    else
    begin
      @(posedge clk_6M);
      tx_start <= 1'b1;
      @(posedge clk_6M);
      tx_start <= 1'b0;
    end
  endtask

  task automatic contend_writes(input int r);
    for (int k = 0; k < 4; k++)
      write_word(8'(HI_ADDR + 4 * r + k), $urandom);
  endtask

  task automatic compare_packet(input int r);
    if (got_bits.size() != exp_bits.size())
    begin
      $display("Mismatch bit_count row %0d: got %h, expected %h",
               r, got_bits.size(), exp_bits.size());
      n_mismatch++;
    end
    else
      for (int i = 0; i < exp_bits.size(); i++)
        if (got_bits[i] !== exp_bits[i])
        begin
          $display("Mismatch txbit row %0d bit %0d: got %h, expected %h",
                   r, i, got_bits[i], exp_bits[i]);
          n_mismatch++;
        end
  endtask

  initial
  begin
    bt_buf_pkg::buf_word_t rd;
    int                    nwords;
    rstz        = 1'b0;
    tx_start    = 1'b0;
    lt_addr     = '0;
    pk_type     = bt_pkt_pkg::NULL_PK;
    flow        = 1'b0;
    arqn        = 1'b0;
    seqn        = 1'b0;
    uap         = '0;
    pylen       = '0;
    whiten_en   = 1'b0;
    whiten_init = '0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    n_mismatch  = 0;
    n_proto     = 0;
    void'($urandom(54016));
    for (int a = 0; a < 256; a++)
      written[a] = 1'b0;
    rows[0] = '{3'd5, bt_pkt_pkg::NULL_PK, 1'b1, 1'b0, 1'b1, 8'h47, 10'd0, 1'b0, 6'h00};
    rows[1] = '{3'd2, bt_pkt_pkg::DH1_PK, 1'b0, 1'b1, 1'b0, 8'hC3, 10'd17, 1'b0, 6'h00};
    rows[2] = '{3'd7, bt_pkt_pkg::DH1_PK, 1'b1, 1'b1, 1'b0, 8'h5A, 10'd10, 1'b1, 6'h2B};
    rows[3] = '{3'd1, bt_pkt_pkg::POLL_PK, 1'b0, 1'b0, 1'b1, 8'h9E, 10'd0, 1'b1, 6'h3F};
    rows[4] = '{3'd4, bt_pkt_pkg::DM1_PK, 1'b1, 1'b0, 1'b0, 8'h11, 10'd6, 1'b0, 6'h00};

    repeat (8) @(posedge clk_6M);
    rstz <= 1'b1;
    repeat (2) @(negedge clk_6M);
    if (tx_busy || txbit_strobe || tx_done)
    begin
      $display("Error: transmitter outputs not idle after reset");
      n_proto++;
    end

    for (int r = 0; r < NROWS; r++)
    begin
      nwords = (int'(rows[r].pylen) + 3) / 4;
      for (int i = 0; i < nwords * 4; i++)
        pbytes[i] = 8'($urandom);
      for (int w = 0; w < nwords; w++)
        write_word(8'(w), {pbytes[4*w+3], pbytes[4*w+2], pbytes[4*w+1], pbytes[4*w]});
      build_expected(rows[r]);
      start_packet(rows[r]);
      fork
        collect_packet();
        start_while_busy();
        if (carries_payload(rows[r].pk_type))
          contend_writes(r);
      join
      compare_packet(r);
      repeat (4) @(negedge clk_6M);  // idle gap watched by the monitor
    end

    for (int a = 0; a < 256; a++)
      if (written[a])
      begin
        host_access(1'b0, 8'(a), '0, rd);
        if (rd !== shadow[a])
        begin
          $display("Mismatch host_rdata addr %h: got %h, expected %h", a, rd, shadow[a]);
          n_mismatch++;
        end
      end

    $display("errors: %0d mismatches, %0d protocol", n_mismatch, n_proto);
    if (n_mismatch == 0 && n_proto == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
